// File: src/divider_params.svh
`ifndef DIVIDER_PARAMS_SVH
`define DIVIDER_PARAMS_SVH

// operand and result width
`define DIV_WIDTH 16

// enough bits to index any bit of a word
`define DIV_IDX_WIDTH 4

// bits per group in the leading-one encoder
`define DIV_GROUP 4

`endif

// File: src/dividerPkg.sv
`include "divider_params.svh"

package dividerPkg;

   // unsigned operand, quotient and remainder
   typedef logic [`DIV_WIDTH-1:0] word_t;

   // bit position or shift distance within a word
   typedef logic [`DIV_IDX_WIDTH-1:0] bitIdx_t;

   // controller states
   typedef enum logic [1:0] {
      stIdle,  // waiting for req
      stAlign, // operands loaded, divisor gets aligned
      stStep,  // one compare-and-subtract per clock
      stDone   // ack high until req drops
   } divState_t;

endpackage

// File: src/priorityEncoder.sv
`include "divider_params.svh"

module priorityEncoder
   import dividerPkg::*;
(
   input  word_t   in,
   output bitIdx_t index,
   output logic    valid
);

   localparam int NumGroups = `DIV_WIDTH / `DIV_GROUP;

   logic [NumGroups-1:0]  groupHit;  // one flag per nibble
   logic [1:0]            groupIdx;
   logic [`DIV_GROUP-1:0] groupBits; // winning nibble
   logic [1:0]            lowIdx;

   // highest set bit of a nibble, zero when empty
   function automatic logic [1:0] encode4(input logic [3:0] bits);
      logic [1:0] pos;
      pos[1] = bits[3] | bits[2];
      pos[0] = bits[3] | (bits[1] & ~bits[2]);
      return pos;
   endfunction

   // first level, which nibbles hold a one
   always_comb begin
      for (int g = 0; g < NumGroups; g++) begin
         groupHit[g] = |in[g*`DIV_GROUP +: `DIV_GROUP];
      end
   end

   assign groupIdx = encode4(groupHit); // upper index bits

   // second level works inside the chosen nibble
   assign groupBits = in[groupIdx*`DIV_GROUP +: `DIV_GROUP];
   assign lowIdx    = encode4(groupBits);

   assign index = {groupIdx, lowIdx};
   assign valid = |groupHit;

endmodule

// File: src/alignShifter.sv
`include "divider_params.svh"

module alignShifter
   import dividerPkg::*;
(
   input  word_t   value,
   input  bitIdx_t amount,
   output word_t   shifted
);

   word_t layer0; // after the 1-bit stage
   word_t layer1; // after the 2-bit stage
   word_t layer2; // after the 4-bit stage

   // each layer moves by a power of two under one amount bit,
   // zeros come in from the right
   assign layer0 = amount[0] ? {value[`DIV_WIDTH-2:0], 1'b0} : value;

   assign layer1 = amount[1] ? {layer0[`DIV_WIDTH-3:0], 2'b00} : layer0;

   assign layer2 = amount[2] ? {layer1[`DIV_WIDTH-5:0], 4'b0000} : layer1;

   assign shifted = amount[3] ? {layer2[`DIV_WIDTH-9:0], 8'h00} : layer2; // last stage

endmodule

// File: src/trialSubtractor.sv
`include "divider_params.svh"

module trialSubtractor
   import dividerPkg::*;
(
   input  word_t partial,
   input  word_t divisor,
   output logic  quotientBit,
   output word_t nextPartial
);

   logic [`DIV_WIDTH:0] diff; // one extra bit to catch the borrow

   assign diff = {1'b0, partial} - {1'b0, divisor};

   // no borrow means partial >= divisor
   assign quotientBit = ~diff[`DIV_WIDTH];

   // restore by keeping the old partial when the subtract fails
   assign nextPartial = quotientBit ? diff[`DIV_WIDTH-1:0] : partial;

endmodule

// File: src/divDatapath.sv
`include "divider_params.svh"

module divDatapath
   import dividerPkg::*;
(
   input  logic    clk,
   input  logic    rstN,
   input  logic    load,
   input  logic    align,
   input  logic    step,
   input  word_t   dividend,
   input  word_t   divisor,
   output bitIdx_t shiftAmt,
   output logic    skip,
   output word_t   quotient,
   output word_t   remainder,
   output logic    divByZero
);

   word_t   dividendReg;
   word_t   divisorReg;  // operand, then aligned, then shifted down each step
   bitIdx_t dividendIdx;
   bitIdx_t divisorIdx;
   logic    divisorValid;
   word_t   alignedDivisor;
   logic    quotientBit;
   word_t   nextPartial;

   // leading ones of both operands
   priorityEncoder dividendEnc (
      .in    (dividendReg),
      .index (dividendIdx),
      .valid ()
   );

   priorityEncoder divisorEnc (
      .in    (divisorReg),
      .index (divisorIdx),
      .valid (divisorValid)
   );

   assign shiftAmt = dividendIdx - divisorIdx; // only meaningful when skip is low

   // zero divisor or a dividend below the divisor needs no steps
   assign skip = !divisorValid || (dividendReg < divisorReg);

   alignShifter aligner (
      .value   (divisorReg),
      .amount  (shiftAmt),
      .shifted (alignedDivisor)
   );

   trialSubtractor trial (
      .partial     (remainder),
      .divisor     (divisorReg),
      .quotientBit (quotientBit),
      .nextPartial (nextPartial)
   );

   // operand registers
   always_ff @(posedge clk) begin
      if (load) begin
         dividendReg <= dividend;
         divisorReg  <= divisor;
      end else if (align) begin
         divisorReg <= alignedDivisor;     // leading ones line up
      end else if (step) begin
         divisorReg <= divisorReg >> 1;
      end
   end

   // results
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         quotient  <= '0;
         remainder <= '0;
         divByZero <= 1'b0;
      end else if (load) begin
         quotient  <= '0;
         divByZero <= (divisor == '0);
      end else if (align) begin
         remainder <= dividendReg;
         if (divByZero) begin
            quotient <= '1;                // fixed all-ones answer
         end
      end else if (step) begin
         quotient  <= {quotient[`DIV_WIDTH-2:0], quotientBit};
         remainder <= nextPartial;
      end
   end

endmodule

// File: src/divControl.sv
module divControl
   import dividerPkg::*;
(
   input  logic    clk,
   input  logic    rstN,
   input  logic    req,
   input  bitIdx_t shiftAmt,
   input  logic    skip,
   output logic    load,
   output logic    align,
   output logic    step,
   output logic    ack
);

   divState_t state;
   divState_t nextState;
   bitIdx_t   stepCount; // steps left after the current one

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= stIdle;
      end else begin
         state <= nextState;
      end
   end

   // loaded while aligning, counts down while stepping
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         stepCount <= '0;
      end else if (align) begin
         stepCount <= shiftAmt;
      end else if (step && stepCount != '0) begin
         stepCount <= stepCount - 1'b1;
      end
   end

   always_comb begin
      nextState = state;
      case (state)
         stIdle: begin
            if (req) begin
               nextState = stAlign;
            end
         end
         stAlign: begin
            nextState = skip ? stDone : stStep;
         end
         stStep: begin
            if (stepCount == '0) begin  // this is the last step
               nextState = stDone;
            end
         end
         stDone: begin
            if (!req) begin
               nextState = stIdle;      // ack drops on this edge
            end
         end
         default: nextState = stIdle;
      endcase
   end

   // strobes to the datapath
   assign load  = (state == stIdle) && req;
   assign align = (state == stAlign);
   assign step  = (state == stStep);

   assign ack = (state == stDone); // results stay put here

endmodule

// File: src/dividerTop.sv
module dividerTop
   import dividerPkg::*;
(
   input  logic  clk,
   input  logic  rstN,
   input  logic  req,
   input  word_t dividend,
   input  word_t divisor,
   output logic  ack,
   output word_t quotient,
   output word_t remainder,
   output logic  divByZero
);

   logic    load;
   logic    align;
   logic    step;
   bitIdx_t shiftAmt;
   logic    skip;    // result known without any steps

   divControl control (
      .clk      (clk),
      .rstN     (rstN),
      .req      (req),
      .shiftAmt (shiftAmt),
      .skip     (skip),
      .load     (load),
      .align    (align),
      .step     (step),
      .ack      (ack)
   );

   divDatapath datapath (
      .clk       (clk),
      .rstN      (rstN),
      .load      (load),
      .align     (align),
      .step      (step),
      .dividend  (dividend),
      .divisor   (divisor),
      .shiftAmt  (shiftAmt),
      .skip      (skip),
      .quotient  (quotient),
      .remainder (remainder),
      .divByZero (divByZero)
   );

endmodule

// File: verif/dividerChecks.sv
module dividerChecks
   import dividerPkg::*;
(
   input logic  clk,
   input logic  rstN,
   input logic  req,
   input word_t dividend,
   input word_t divisor,
   input logic  ack,
   input word_t quotient,
   input word_t remainder,
   input logic  divByZero,
   input word_t expQuotient,
   input word_t expRemainder,
   input logic  expDivByZero
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int MaxLatency  = 19;
   localparam int SkipLatency = 3; // load, align, done

   int   valueErrors = 0;
   int   protocolErrors = 0;
   logic seenReq;   // set once the first req arrives
   int   reqCycles; // counts the cycle that raised req as one

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         seenReq   <= 1'b0;
         reqCycles <= 1;
      end else begin
         if (req) begin
            seenReq <= 1'b1;
         end
         if (!req) begin
            reqCycles <= 1;
         end else if (!ack) begin
            reqCycles <= reqCycles + 1;
         end
      end
   end

   // quiet outputs between reset and the first request
   resetQuotient: assert property (@(posedge clk) disable iff (!rstN)
      !seenReq |-> quotient == '0)
      else begin
         valueErrors++;
         $error("error quotient expected 0000 got %h", $sampled(quotient));
      end

   resetRemainder: assert property (@(posedge clk) disable iff (!rstN)
      !seenReq |-> remainder == '0)
      else begin
         valueErrors++;
         $error("error remainder expected 0000 got %h", $sampled(remainder));
      end

   resetFlags: assert property (@(posedge clk) disable iff (!rstN)
      !seenReq |-> !ack && !divByZero)
      else begin
         valueErrors++;
         $error("error ack/divByZero expected 0/0 got %h/%h",
                $sampled(ack), $sampled(divByZero));
      end

   // results at every rising ack
   quotientValue: assert property (@(posedge clk) disable iff (!rstN)
      $rose(ack) |-> quotient == expQuotient)
      else begin
         valueErrors++;
         $error("error quotient expected %h got %h", $sampled(expQuotient),
                $sampled(quotient));
      end

   remainderValue: assert property (@(posedge clk) disable iff (!rstN)
      $rose(ack) |-> remainder == expRemainder)
      else begin
         valueErrors++;
         $error("error remainder expected %h got %h", $sampled(expRemainder),
                $sampled(remainder));
      end

   divByZeroValue: assert property (@(posedge clk) disable iff (!rstN)
      $rose(ack) |-> divByZero == expDivByZero)
      else begin
         valueErrors++;
         $error("error divByZero expected %h got %h", $sampled(expDivByZero),
                $sampled(divByZero));
      end

   belowQuotient: assert property (@(posedge clk) disable iff (!rstN)
      $rose(ack) && dividend < divisor |-> quotient == '0)
      else begin
         valueErrors++;
         $error("error quotient expected 0000 got %h", $sampled(quotient));
      end

   // timing of the handshake
   belowLatency: assert property (@(posedge clk) disable iff (!rstN)
      $rose(ack) && dividend < divisor |-> reqCycles == SkipLatency)
      else begin
         protocolErrors++;
         $error("ack came after %0d cycles for a dividend below the divisor, not %0d",
                $sampled(reqCycles), SkipLatency);
      end

   maxLatency: assert property (@(posedge clk) disable iff (!rstN)
      $rose(ack) |-> reqCycles <= MaxLatency)
      else begin
         protocolErrors++;
         $error("ack took %0d cycles, more than %0d", $sampled(reqCycles), MaxLatency);
      end

   ackNeedsReq: assert property (@(posedge clk) disable iff (!rstN)
      $rose(ack) |-> $past(req))
      else begin
         protocolErrors++;
         $error("ack rose while req was low");
      end

   holdWhileAck: assert property (@(posedge clk) disable iff (!rstN)
      ack && req |=> ack && $stable(quotient) && $stable(remainder) && $stable(divByZero))
      else begin
         protocolErrors++;
         $error("ack dropped or the results changed while req was still high");
      end

   ackFollowsReq: assert property (@(posedge clk) disable iff (!rstN)
      $fell(req) |=> $fell(ack))
      else begin
         protocolErrors++;
         $error("ack did not fall one cycle after req fell");
      end

endmodule

// File: verif/dividerTb.sv
`include "divider_params.svh"

module dividerTb
   import dividerPkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ClkPeriod      = 40;
   localparam int DriveDelay     = 2;   // inputs change this long after the edge
   localparam int ResetCycles    = 8;
   localparam int NumRandom      = 200;
   localparam int NumDirected    = 7;
   localparam int NumTrans       = NumRandom + NumDirected;
   localparam int CyclesPerTrans = 25;
   localparam int WatchdogCycles = NumTrans * CyclesPerTrans + ResetCycles;

   logic  clk;
   logic  rstN;
   logic  req;
   word_t dividend;
   word_t divisor;
   logic  ack;
   word_t quotient;
   word_t remainder;
   logic  divByZero;

   // expected results of the division in flight
   word_t expQuotient;
   word_t expRemainder;
   logic  expDivByZero;

   int seed = 37;
   int doneCount = 0;

   dividerTop DUT (
      .clk       (clk),
      .rstN      (rstN),
      .req       (req),
      .dividend  (dividend),
      .divisor   (divisor),
      .ack       (ack),
      .quotient  (quotient),
      .remainder (remainder),
      .divByZero (divByZero)
   );

   bind dividerTop dividerChecks checks (
      .clk          (clk),
      .rstN         (rstN),
      .req          (req),
      .dividend     (dividend),
      .divisor      (divisor),
      .ack          (ack),
      .quotient     (quotient),
      .remainder    (remainder),
      .divByZero    (divByZero),
      .expQuotient  (dividerTb.expQuotient),
      .expRemainder (dividerTb.expRemainder),
      .expDivByZero (dividerTb.expDivByZero)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(ClkPeriod / 2) clk = ~clk;
      end
   end

   // step to just past the next rising edge
   task automatic nextCycle();
      @(posedge clk);
      #DriveDelay;
   endtask

   // prints the closing count line and the verdict, then ends the run
   task automatic closeRun(input int timeouts);
      int total;
      total = DUT.checks.valueErrors + DUT.checks.protocolErrors + timeouts;
      $display("errors: value %0d, protocol %0d, timeout %0d, divisions done %0d",
               DUT.checks.valueErrors, DUT.checks.protocolErrors, timeouts, doneCount);
      if (total == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   endtask

   // one full four-phase handshake
   task automatic runDivision(input word_t a, input word_t b);
      int holdCycles;
      holdCycles = $unsigned($random(seed)) % 4; // extra cycles with req held
      if (b == '0) begin
         expQuotient  = '1;   // fixed divide-by-zero answer
         expRemainder = a;
         expDivByZero = 1'b1;
      end else begin
         expQuotient  = a / b;
         expRemainder = a % b;
         expDivByZero = 1'b0;
      end
      dividend = a;
      divisor  = b;
      req      = 1'b1;
      do begin
         nextCycle();
      end while (!ack);
      repeat (holdCycles) begin
         nextCycle();
      end
      req = 1'b0;
      do begin
         nextCycle();
      end while (ack);
      doneCount++;
   endtask

   // operands of varied magnitude, now and then a zero divisor
   task automatic randomOperands(output word_t a, output word_t b);
      int aShift;
      int bShift;
      aShift = $unsigned($random(seed)) % 8;
      bShift = $unsigned($random(seed)) % 16;
      a = word_t'($random(seed)) >> aShift;
      b = word_t'($random(seed)) >> bShift;
      if ($unsigned($random(seed)) % 20 == 0) begin
         b = '0;
      end
   endtask

   initial begin
      word_t a;
      word_t b;
      rstN         = 1'b0;
      req          = 1'b0;
      dividend     = '0;
      divisor      = '0;
      expQuotient  = '0;
      expRemainder = '0;
      expDivByZero = 1'b0;

      repeat (ResetCycles) begin
         @(posedge clk);
      end
      #DriveDelay;
      rstN = 1'b1;
      repeat (3) begin
         nextCycle();      // idle a little, outputs must stay cleared
      end

      // corner cases first
      runDivision(16'hFFFF, 16'h0001);
      runDivision(16'h8000, 16'h8000);
      runDivision(16'h0001, 16'hFFFF);
      runDivision(16'h1234, 16'h0000);
      runDivision(16'h0000, 16'h0000);
      runDivision(16'h0000, 16'h0005);
      runDivision(16'h0007, 16'h0009);

      for (int i = 0; i < NumRandom; i++) begin
         randomOperands(a, b);
         runDivision(a, b);
      end

      repeat (4) begin
         nextCycle();
      end
      closeRun(0);
   end

   // watchdog sized from the number of divisions
   initial begin
      #(WatchdogCycles * ClkPeriod);
      $display("timeout: the divider did not finish all %0d divisions in time", NumTrans);
      closeRun(1);
   end

endmodule

// File: build.f
+incdir+src
src/dividerPkg.sv
src/priorityEncoder.sv
src/alignShifter.sv
src/trialSubtractor.sv
src/divDatapath.sv
src/divControl.sv
src/dividerTop.sv
verif/dividerChecks.sv
verif/dividerTb.sv
